// ==== include/axis_in_cfg.svh ====
`ifndef AXIS_IN_CFG_SVH
`define AXIS_IN_CFG_SVH

// Stream byte and CPU word widths
`define AXIS_IN_TDATA_W 8
`define AXIS_IN_DATA_W 32

// Word FIFO holds 2**4 entries
`define AXIS_IN_FIFO_DEPTH_LOG2 4

// CPU word address width and register map
`define AXIS_IN_ADDR_W 2
`define AXIS_IN_REG_DATA 2'd0
`define AXIS_IN_REG_EMPTY 2'd1
`define AXIS_IN_REG_LAST 2'd2
`define AXIS_IN_REG_CTRL 2'd3

`endif

// ==== list.f ====
+incdir+include
src/axis_in_pkg.sv
src/axis_in_if.sv
src/axis_in_fifo.sv
src/axis_in_packer.sv
src/axis_in_regs.sv
src/axis_in_top.sv
tb/axis_in_props.sv
tb/axis_in_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module axis_in_tb -f list.f -o axis_in_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/axis_in_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== src/axis_in_fifo.sv ====
`timescale 1ns/1ps
`include "axis_in_cfg.svh"

module axis_in_fifo (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               wr_en,
   input  axis_in_pkg::word_t wr_word,
   output logic               full,
   word_pop_if.fifo           pop_port
);
   import axis_in_pkg::*;

   localparam int AW = `AXIS_IN_FIFO_DEPTH_LOG2;
   localparam int DEPTH = 1 << AW;

   word_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   level_t        count;
   logic          push;
   logic          pop;

   assign full = (count == level_t'(DEPTH));
   assign pop_port.empty = (count == '0);
   assign pop_port.level = count;
   // First word fall-through, head is always on the read port
   assign pop_port.head_word = mem[rd_ptr];

   // Ignore requests that would overflow or underflow
   assign push = wr_en && !full;
   assign pop = pop_port.pop && !pop_port.empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_word;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (pop_port.flush) begin
         // Flush wins over a push in the same cycle
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Level holds on simultaneous push and pop
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== src/axis_in_if.sv ====
`timescale 1ns/1ps

// Packet end status and CPU control between packer and register block
interface packet_ctl_if;
   import axis_in_pkg::*;

   logic  last_seen;
   strb_t last_strb;
   // Named pkt_release since release is a keyword
   logic  pkt_release;
   logic  flush;

   modport packer (output last_seen, output last_strb, input pkt_release, input flush);
   modport regs (input last_seen, input last_strb, output pkt_release, output flush);
endinterface

// Read side of the word FIFO, seen from the register block
interface word_pop_if;
   import axis_in_pkg::*;

   logic   pop;
   word_t  head_word;
   logic   empty;
   level_t level;
   logic   flush;

   modport fifo (input pop, input flush, output head_word, output empty, output level);
   modport regs (output pop, output flush, input head_word, input empty, input level);
endinterface

// ==== src/axis_in_packer.sv ====
`timescale 1ns/1ps
`include "axis_in_cfg.svh"

module axis_in_packer (
   input  logic               clk,
   input  logic               rst_n,
   input  axis_in_pkg::byte_t tdata,
   input  logic               tvalid,
   input  logic               tlast,
   output logic               tready,
   output logic               wr_en,
   output axis_in_pkg::word_t wr_word,
   input  logic               full,
   packet_ctl_if.packer       ctl
);
   import axis_in_pkg::*;

   localparam int BYTE_W = `AXIS_IN_TDATA_W;
   localparam int LANES = `AXIS_IN_DATA_W / `AXIS_IN_TDATA_W;
   localparam int IDX_W = $clog2(LANES);

   pack_state_t      state;
   // Lane of the next byte
   logic [IDX_W-1:0] idx;
   // Bytes of the word under assembly
   word_t            part;
   strb_t            lane_strb;
   strb_t            strb_q;
   // Keeps tready low until the first edge after reset
   logic             started;
   logic             accept;
   logic             word_done;

   assign tready = started && (state == PACK_RUN) && !full;
   assign accept = tvalid && tready;
   // Word closes on the top lane or on the packet end
   assign word_done = (idx == IDX_W'(LANES - 1)) || tlast;
   assign wr_en = accept && word_done;

   assign ctl.last_seen = (state == PACK_HOLD);
   assign ctl.last_strb = strb_q;

   // Merge new byte into its lane, lanes above it read as zero
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         if (i == int'(idx)) begin
            wr_word[i*BYTE_W +: BYTE_W] = tdata;
         end else if (i < int'(idx)) begin
            wr_word[i*BYTE_W +: BYTE_W] = part[i*BYTE_W +: BYTE_W];
         end else begin
            wr_word[i*BYTE_W +: BYTE_W] = '0;
         end
         // Lanes filled up to and including this byte
         lane_strb[i] = (i <= int'(idx));
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
         state   <= PACK_RUN;
         idx     <= '0;
         strb_q  <= '0;
      end else begin
         started <= 1'b1;
         if (ctl.flush || ctl.pkt_release) begin
            // Back to streaming, any partial word is dropped
            state  <= PACK_RUN;
            idx    <= '0;
            strb_q <= '0;
         end else if (accept) begin
            idx <= word_done ? '0 : idx + 1'b1;
            if (tlast) begin
               state  <= PACK_HOLD;
               strb_q <= lane_strb;
            end
         end
      end
   end

   // Lanes below idx are valid only
   always_ff @(posedge clk) begin
      if (accept) begin
         part <= wr_word;
      end
   end

endmodule

// ==== src/axis_in_pkg.sv ====
`include "axis_in_cfg.svh"

package axis_in_pkg;

   // One stream beat
   typedef logic [`AXIS_IN_TDATA_W-1:0] byte_t;

   // FIFO entry and CPU bus word
   typedef logic [`AXIS_IN_DATA_W-1:0] word_t;

   // One bit per byte lane of a word
   typedef logic [`AXIS_IN_DATA_W/`AXIS_IN_TDATA_W-1:0] strb_t;

   // CPU word address
   typedef logic [`AXIS_IN_ADDR_W-1:0] reg_addr_t;

   // FIFO fill count, needs one extra bit to hold the full depth
   typedef logic [`AXIS_IN_FIFO_DEPTH_LOG2:0] level_t;

   // Packer states
   typedef enum logic {
      PACK_RUN,
      PACK_HOLD
   } pack_state_t;

endpackage

// ==== src/axis_in_regs.sv ====
`timescale 1ns/1ps
`include "axis_in_cfg.svh"

module axis_in_regs (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   valid,
   input  axis_in_pkg::reg_addr_t address,
   input  axis_in_pkg::word_t     wdata,
   input  axis_in_pkg::strb_t     wstrb,
   output axis_in_pkg::word_t     rdata,
   output logic                   ready,
   packet_ctl_if.regs             ctl,
   word_pop_if.regs               pop_port
);
   import axis_in_pkg::*;

   localparam int LAST_MSB = $bits(strb_t);

   // First cycle of a request
   logic  req;
   logic  is_write;
   word_t rd_mux;
   // Side effects, each lands on the ready edge
   logic  pop_pend;
   logic  rel_pend;
   logic  flush_pend;

   // Master holds valid through ready, so ignore it while ready is up
   assign req = valid && !ready;
   assign is_write = |wstrb;

   // Read data select
   always_comb begin
      rd_mux = '0;
      case (address)
         `AXIS_IN_REG_DATA: begin
            // Empty queue reads as zero
            if (!pop_port.empty) begin
               rd_mux = pop_port.head_word;
            end
         end
         `AXIS_IN_REG_EMPTY: rd_mux[0] = pop_port.empty;
         `AXIS_IN_REG_LAST:  rd_mux[LAST_MSB:0] = {ctl.last_seen, ctl.last_strb};
         `AXIS_IN_REG_CTRL:  rd_mux = word_t'(pop_port.level);
         default:            rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready      <= 1'b0;
         pop_pend   <= 1'b0;
         rel_pend   <= 1'b0;
         flush_pend <= 1'b0;
      end else begin
         ready <= req;
         // Pop only a word that was actually returned
         pop_pend <= req && !is_write && (address == `AXIS_IN_REG_DATA) && !pop_port.empty;
         // Release only once the packet has been drained
         rel_pend <= req && !is_write && (address == `AXIS_IN_REG_LAST)
                     && pop_port.empty && ctl.last_seen;
         flush_pend <= req && is_write && (address == `AXIS_IN_REG_CTRL)
                       && wstrb[0] && wdata[0];
      end
   end

   // Captured on request, presented with ready
   always_ff @(posedge clk) begin
      if (req) begin
         rdata <= is_write ? '0 : rd_mux;
      end
   end

   assign pop_port.pop = pop_pend;
   assign ctl.pkt_release = rel_pend;
   // Same flush pulse clears queue and packet state
   assign ctl.flush = flush_pend;
   assign pop_port.flush = flush_pend;

endmodule

// ==== src/axis_in_top.sv ====
`timescale 1ns/1ps

module axis_in_top (
   input  logic                   clk,
   input  logic                   rst_n,
   // Byte stream in
   input  axis_in_pkg::byte_t     tdata,
   input  logic                   tvalid,
   output logic                   tready,
   input  logic                   tlast,
   // CPU register bus
   input  logic                   valid,
   input  axis_in_pkg::reg_addr_t address,
   input  axis_in_pkg::word_t     wdata,
   input  axis_in_pkg::strb_t     wstrb,
   output axis_in_pkg::word_t     rdata,
   output logic                   ready
);
   import axis_in_pkg::*;

   // Packer to FIFO write side
   logic  wr_en;
   word_t wr_word;
   logic  full;

   packet_ctl_if ctl_if ();
   word_pop_if   pop_if ();

   axis_in_packer packer0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .tdata   (tdata),
      .tvalid  (tvalid),
      .tlast   (tlast),
      .tready  (tready),
      .wr_en   (wr_en),
      .wr_word (wr_word),
      .full    (full),
      .ctl     (ctl_if.packer)
   );

   axis_in_fifo fifo0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en),
      .wr_word  (wr_word),
      .full     (full),
      .pop_port (pop_if.fifo)
   );

   axis_in_regs regs0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .valid    (valid),
      .address  (address),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .rdata    (rdata),
      .ready    (ready),
      .ctl      (ctl_if.regs),
      .pop_port (pop_if.regs)
   );

endmodule

// ==== tb/axis_in_props.sv ====
`timescale 1ns/1ps

module axis_in_props (
   input logic clk,
   input logic rst_n,
   input logic valid,
   input logic ready,
   input logic tvalid,
   input logic tready,
   input logic tlast
);

   // Slave answers one cycle after a new request
   a_ready_follows_valid: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(valid) |=> ready)
      else $error("ready did not rise one cycle after valid");

   // Single cycle ready pulse
   a_ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ready |=> !ready)
      else $error("ready high for two cycles running");

   // Packet end closes the stream
   a_hold_after_tlast: assert property (@(posedge clk) disable iff (!rst_n)
      (tvalid && tready && tlast) |=> !tready)
      else $error("tready high in the cycle after tlast");

   // No transfers during reset
   a_tready_in_reset: assert property (@(posedge clk)
      !rst_n |-> !tready)
      else $error("tready high while in reset");

endmodule

bind axis_in_top axis_in_props props0 (
   .clk    (clk),
   .rst_n  (rst_n),
   .valid  (valid),
   .ready  (ready),
   .tvalid (tvalid),
   .tready (tready),
   .tlast  (tlast)
);

// ==== tb/axis_in_tb.sv ====
`timescale 1ns/1ps

module axis_in_tb;
   import axis_in_pkg::*;

   logic      clk;
   logic      rst_n;
   byte_t     tdata;
   logic      tvalid;
   logic      tready;
   logic      tlast;
   logic      valid;
   reg_addr_t address;
   word_t     wdata;
   strb_t     wstrb;
   word_t     rdata;
   logic      ready;

   // Operations from the data file
   string op_q[$];
   int    cnt_q[$];
   word_t f1_q[$];
   word_t f2_q[$];
   word_t f3_q[$];
   string name_q[$];
   int    line_count;
   bit    loaded;
   int    errors;
   int    checks;

   axis_in_top dut0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .tdata   (tdata),
      .tvalid  (tvalid),
      .tready  (tready),
      .tlast   (tlast),
      .valid   (valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (rdata),
      .ready   (ready)
   );

   always #2 clk = ~clk;

   task automatic check(input string name, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   // Random idle gap, then hold the byte until the handshake edge
   task automatic send_byte(input byte_t b, input logic l);
      int gap;
      gap = $urandom % 4;
      repeat (gap) @(negedge clk);
      tdata = b;
      tvalid = 1'b1;
      tlast = l;
      // tready is stable at the falling edge
      while (!tready) @(negedge clk);
      @(negedge clk);
      tvalid = 1'b0;
      tlast = 1'b0;
   endtask

   // One bus request held until ready, data taken in the ready cycle
   task automatic bus_access(input reg_addr_t a, input word_t d, input strb_t s,
                             output word_t q);
      valid = 1'b1;
      address = a;
      wdata = d;
      wstrb = s;
      @(negedge clk);
      while (!ready) @(negedge clk);
      q = rdata;
      valid = 1'b0;
      wstrb = '0;
      // Ready pulse ends and the pop or release lands
      @(negedge clk);
   endtask

   function automatic bit load_file();
      int    fd;
      int    r;
      string line;
      string op;
      string name;
      int    cnt;
      word_t a;
      word_t b;
      word_t c;
      fd = $fopen("tb/axis_in_testdata.txt", "r");
      if (fd == 0) begin
         return 1'b0;
      end
      while (!$feof(fd)) begin
         line = "";
         r = $fgets(line, fd);
         line_count++;
         cnt = 1;
         a = '0;
         b = '0;
         c = '0;
         name = "";
         // Skip blank and comment lines
         if (line.len() > 1 && line.getc(0) != "#") begin
            r = $sscanf(line, "%s", op);
            if (op == "S") begin
               r = $sscanf(line, "%s %d %h %h %d", op, cnt, a, b, c);
            end else if (op == "R") begin
               r = $sscanf(line, "%s %d %h %h %h %s", op, cnt, a, b, c, name);
            end else if (op == "W") begin
               r = $sscanf(line, "%s %h %h", op, a, b);
            end else begin
               r = $sscanf(line, "%s %d %s", op, a, name);
            end
            op_q.push_back(op);
            cnt_q.push_back(cnt);
            f1_q.push_back(a);
            f2_q.push_back(b);
            f3_q.push_back(c);
            name_q.push_back(name);
         end
      end
      $fclose(fd);
      return 1'b1;
   endfunction

   task automatic run_op(input int i);
      word_t q;
      word_t exp;
      exp = f2_q[i];
      if (op_q[i] == "S") begin
         // Byte values step from the first one, tlast only on the final byte
         for (int k = 0; k < cnt_q[i]; k++) begin
            send_byte(byte_t'(f1_q[i] + word_t'(k) * f2_q[i]),
                      f3_q[i][0] && (k == cnt_q[i] - 1));
         end
      end else if (op_q[i] == "R") begin
         for (int k = 0; k < cnt_q[i]; k++) begin
            bus_access(reg_addr_t'(f1_q[i]), '0, '0, q);
            check($sformatf("%s_%0d", name_q[i], k), exp, q);
            exp = exp + f3_q[i];
         end
      end else if (op_q[i] == "W") begin
         bus_access(reg_addr_t'(f1_q[i]), f2_q[i], 4'hf, q);
      end else if (op_q[i] == "T") begin
         check(name_q[i], f1_q[i], word_t'(tready));
      end else begin
         errors++;
         $display("Error: unknown operation %s in the test data", op_q[i]);
      end
   endtask

   initial begin
      void'($urandom(83));
      clk = 1'b0;
      rst_n = 1'b0;
      tdata = '0;
      tvalid = 1'b0;
      tlast = 1'b0;
      valid = 1'b0;
      address = '0;
      wdata = '0;
      wstrb = '0;
      errors = 0;
      checks = 0;
      line_count = 0;
      if (!load_file()) begin
         $display("Error: could not open tb/axis_in_testdata.txt");
         $display("STATUS: FAIL");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (10) @(negedge clk);
         rst_n = 1'b1;
         // Packer opens tready one edge after reset
         @(negedge clk);
         for (int i = 0; i < op_q.size(); i++) begin
            run_op(i);
         end
         $display("checks %0d errors %0d", checks, errors);
         if (errors == 0) begin
            $display("STATUS: PASS");
         end else begin
            $display("STATUS: FAIL");
         end
         $finish;
      end
   end

   // 200 clock cycles of 4 ns per data file line
   initial begin
      wait (loaded);
      #(line_count * 200 * 4);
      $display("Error: timeout, run not finished after %0d ns", line_count * 800);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== tb/axis_in_testdata.txt ====
# S count first_byte byte_step last | R count addr expected step name
# W addr data | T tready_expected name (counts decimal, other values hex)
R 1 1 1 0 empty_after_reset
S 4 11 11 0
R 1 3 1 0 level_one
R 1 0 44332211 0 packed_word
R 1 3 0 0 level_zero
R 1 1 1 0 empty_drained
R 1 0 0 0 data_when_empty
R 1 3 0 0 level_after_empty_read
S 6 a0 1 1
R 1 2 13 0 last_held
R 1 3 2 0 level_two
R 1 0 a3a2a1a0 0 pkt_word0
R 1 0 0000a5a4 0 pkt_word1
R 1 2 13 0 last_release
R 1 2 0 0 last_cleared
S 64 0 1 0
R 1 3 10 0 level_full
T 0 tready_full
R 16 0 03020100 04040404 drain_word
S 4 40 1 0
R 1 0 43424140 0 word_17
S 3 b0 1 1
R 1 2 17 0 last_before_flush
W 3 1
R 1 1 1 0 empty_after_flush
R 1 3 0 0 level_after_flush
R 1 2 0 0 last_after_flush
S 4 c0 1 0
R 1 0 c3c2c1c0 0 word_after_flush
